//--- common/cpu_pkg.sv
package cpu_pkg;

	localparam int WORD_W = 32;                      // Bus and data register width
	localparam int REG_COUNT = 16;                   // General registers
	localparam int REG_INDEX_W = $clog2(REG_COUNT);
	localparam int MEM_DEPTH = 512;                  // Memory words
	localparam int MEM_ADDR_W = $clog2(MEM_DEPTH);

	// Instruction field positions
	localparam int OPCODE_MSB = 31;
	localparam int OPCODE_LSB = 27;
	localparam int RA_MSB = 26;
	localparam int RA_LSB = 23;
	localparam int RB_MSB = 22;
	localparam int RB_LSB = 19;
	localparam int RC_MSB = 18;
	localparam int RC_LSB = 15;
	localparam int C_MSB = 18;                       // C spans C_MSB down to bit 0

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [REG_INDEX_W-1:0] reg_index_t;
	typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SUB = 4'd1,
		ALU_AND = 4'd2,
		ALU_OR  = 4'd3
	} alu_op_t;

endpackage

//--- datapath/register_file.sv
`timescale 1ns/1ns

module register_file import cpu_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  reg_index_t reg_index,
	input  logic       ba_read,
	input  logic       write_en,
	input  word_t      write_data,
	output word_t      read_data
);

	word_t regs [REG_COUNT];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < REG_COUNT; i++)
				regs[i] <= '0;
		end else if (write_en) begin
			regs[reg_index] <= write_data;
		end
	end

	// R0 acts as a zero base in address calculations
	always_comb begin
		if (ba_read && reg_index == '0)
			read_data = '0;
		else
			read_data = regs[reg_index];
	end

endmodule

//--- datapath/alu.sv
`timescale 1ns/1ns

module alu import cpu_pkg::*; (
	input  alu_op_t op,
	input  word_t   a,       // From Y
	input  word_t   b,       // From the bus
	output word_t   result
);

	always_comb begin
		case (op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			default: result = '0;  // Unused opcodes
		endcase
	end

endmodule

//--- datapath/datapath.sv
`timescale 1ns/1ns

module datapath import cpu_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  alu_op_t    alu_op,
	input  logic       inc_pc,
	input  logic       mdr_select,
	input  logic       ba_read,
	input  logic       regfile_read,
	input  logic       pc_read,
	input  logic       mdr_read,
	input  logic       z_read,
	input  logic       c_read,
	input  logic       inport_read,
	input  logic       regfile_write,
	input  logic       pc_write,
	input  logic       mdr_write,
	input  logic       ir_write,
	input  logic       y_write,
	input  logic       z_write,
	input  logic       mar_write,
	input  reg_index_t reg_index,
	input  word_t      c_value,
	input  word_t      mem_data,
	input  word_t      inport_data,
	output word_t      bus,
	output word_t      mar,
	output word_t      mdr,
	output word_t      ir
);

	word_t pc;
	word_t y;
	word_t z;
	word_t rf_data;
	word_t alu_result;

	register_file register_file_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.reg_index  (reg_index),
		.ba_read    (ba_read),
		.write_en   (regfile_write),
		.write_data (bus),
		.read_data  (rf_data)
	);

	alu alu_inst (
		.op     (alu_op),
		.a      (y),
		.b      (bus),
		.result (alu_result)
	);

	// One-hot bus mux that is zero when nothing drives it
	assign bus = ({WORD_W{regfile_read | ba_read}} & rf_data)
		| ({WORD_W{pc_read}} & pc)
		| ({WORD_W{mdr_read}} & mdr)
		| ({WORD_W{z_read}} & z)
		| ({WORD_W{c_read}} & c_value)
		| ({WORD_W{inport_read}} & inport_data);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= '0;
			mar <= '0;
			mdr <= '0;
			ir <= '0;
			y <= '0;
			z <= '0;
		end else begin
			if (pc_write)
				pc <= inc_pc ? pc + word_t'(1) : bus;  // Increment or jump from bus
			if (mar_write)
				mar <= bus;
			if (mdr_write)
				mdr <= mdr_select ? mem_data : bus;    // Memory word or bus
			if (ir_write)
				ir <= bus;
			if (y_write)
				y <= bus;                              // Left ALU operand
			if (z_write)
				z <= alu_result;
		end
	end

	// A second driver would OR two values onto the bus
	a_single_bus_source: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({regfile_read, ba_read, pc_read, mdr_read, z_read, c_read, inport_read}))
		else $error("More than one bus source selected");

endmodule

//--- src/select_encode.sv
`timescale 1ns/1ns

module select_encode import cpu_pkg::*; (
	input  word_t      ir,
	input  logic       gra,
	input  logic       grb,
	input  logic       grc,
	output reg_index_t reg_index,
	output word_t      c_value
);

	always_comb begin
		if (gra)
			reg_index = ir[RA_MSB:RA_LSB];
		else if (grb)
			reg_index = ir[RB_MSB:RB_LSB];
		else if (grc)
			reg_index = ir[RC_MSB:RC_LSB];
		else
			reg_index = '0;  // No field selected
	end

	// Sign extension of the constant field
	assign c_value = {{(WORD_W - C_MSB - 1){ir[C_MSB]}}, ir[C_MSB:0]};

	// Checked after the inputs settle within a time step
	always_comb begin
		if (!$isunknown({gra, grb, grc}))
			a_one_field: assert final ($onehot0({gra, grb, grc}))
				else $error("More than one register field select active");
	end

endmodule

//--- src/main_memory.sv
`timescale 1ns/1ns

module main_memory import cpu_pkg::*; (
	input  logic      clk,
	input  mem_addr_t addr,
	input  word_t     write_data,
	input  logic      write_en,
	output word_t     read_data
);

	word_t mem [MEM_DEPTH];

	always_ff @(posedge clk) begin
		if (write_en)
			mem[addr] <= write_data;  // MDR into the word at MAR
	end

	assign read_data = mem[addr];    // Async read from MAR

	a_write_addr_known: assert property (@(posedge clk)
		write_en |-> !$isunknown(addr))
		else $error("Memory write with unknown address");

endmodule

//--- src/cpu_system.sv
`timescale 1ns/1ns

module cpu_system import cpu_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  alu_op_t alu_op,
	input  logic    inc_pc,
	input  logic    mdr_select,
	input  logic    gra,
	input  logic    grb,
	input  logic    grc,
	input  logic    ba_read,
	input  logic    regfile_read,
	input  logic    pc_read,
	input  logic    mdr_read,
	input  logic    z_read,
	input  logic    c_read,
	input  logic    inport_read,
	input  logic    regfile_write,
	input  logic    pc_write,
	input  logic    mdr_write,
	input  logic    ir_write,
	input  logic    y_write,
	input  logic    z_write,
	input  logic    mar_write,
	input  logic    mem_write,
	input  word_t   inport_data,
	output word_t   bus
);

	reg_index_t reg_index;
	word_t c_value;
	word_t mem_data;
	word_t mar;
	word_t mdr;
	word_t ir;

	datapath datapath_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.alu_op        (alu_op),
		.inc_pc        (inc_pc),
		.mdr_select    (mdr_select),
		.ba_read       (ba_read),
		.regfile_read  (regfile_read),
		.pc_read       (pc_read),
		.mdr_read      (mdr_read),
		.z_read        (z_read),
		.c_read        (c_read),
		.inport_read   (inport_read),
		.regfile_write (regfile_write),
		.pc_write      (pc_write),
		.mdr_write     (mdr_write),
		.ir_write      (ir_write),
		.y_write       (y_write),
		.z_write       (z_write),
		.mar_write     (mar_write),
		.reg_index     (reg_index),
		.c_value       (c_value),
		.mem_data      (mem_data),
		.inport_data   (inport_data),
		.bus           (bus),
		.mar           (mar),
		.mdr           (mdr),
		.ir            (ir)
	);

	select_encode select_encode_inst (
		.ir        (ir),
		.gra       (gra),
		.grb       (grb),
		.grc       (grc),
		.reg_index (reg_index),
		.c_value   (c_value)
	);

	main_memory main_memory_inst (
		.clk        (clk),
		.addr       (mar[MEM_ADDR_W-1:0]),  // Word address from low MAR bits
		.write_data (mdr),
		.write_en   (mem_write),
		.read_data  (mem_data)
	);

endmodule

//--- sim/bus_checker.sv
`timescale 1ns/1ns

module bus_checker import cpu_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         check_en,
	input  logic [127:0] test_name,
	input  word_t        expect_bus,
	input  word_t        bus,
	output int           check_count,
	output int           mismatch_count
);

	// Bus value of the step that ends at this edge
	always @(posedge clk) begin
		if (!rst_n) begin
			check_count <= 0;
			mismatch_count <= 0;
		end else if (check_en) begin
			check_count <= check_count + 1;
			if (bus !== expect_bus) begin
				mismatch_count <= mismatch_count + 1;
				$display("Mismatch in %0s at %0t ns: expected %08h, actual %08h",
					test_name, $time, expect_bus, bus);
			end
		end
	end

endmodule

//--- sim/cpu_system_tb.sv
`timescale 1ns/1ns

module cpu_system_tb import cpu_pkg::*; ();

	localparam string PATTERN_FILE = "sim/load_patterns.txt";
	localparam int MAX_STEPS = 128;
	localparam int RESET_CYCLES = 8;
	localparam int TIMEOUT_MARGIN = 20;

	logic clk = 1'b0;
	logic rst_n;
	alu_op_t alu_op;
	logic inc_pc, mdr_select, gra, grb, grc, ba_read;
	logic regfile_read, pc_read, mdr_read, z_read, c_read, inport_read;
	logic regfile_write, pc_write, mdr_write, ir_write;
	logic y_write, z_write, mar_write, mem_write;
	word_t inport_data;
	word_t bus;

	logic check_en;
	logic [127:0] test_name;
	word_t expect_bus;
	int check_count;
	int mismatch_count;

	logic [127:0] step_name [MAX_STEPS];
	logic [23:0] step_ctrl [MAX_STEPS];
	word_t step_inport [MAX_STEPS];
	logic step_check [MAX_STEPS];
	word_t step_expect [MAX_STEPS];
	int step_total = 0;
	int cycle_count = 0;

	always #10 clk = ~clk;  // 20 ns period

	cpu_system cpu_system_inst (.*);

	bus_checker bus_checker_inst (
		.clk            (clk),
		.rst_n          (rst_n),
		.check_en       (check_en),
		.test_name      (test_name),
		.expect_bus     (expect_bus),
		.bus            (bus),
		.check_count    (check_count),
		.mismatch_count (mismatch_count)
	);

	// Bits 19..0 are strobes and selects, bits 23..20 the ALU opcode
	task automatic apply_controls(input logic [23:0] ctrl);
		{mem_write, mar_write, z_write, y_write, ir_write, mdr_write, pc_write,
			regfile_write, inport_read, c_read, z_read, mdr_read, pc_read,
			regfile_read, ba_read, grc, grb, gra, mdr_select, inc_pc} = ctrl[19:0];
		alu_op = alu_op_t'(ctrl[23:20]);
	endtask

	task automatic read_patterns();
		int fd;
		int n;
		int flag;
		string line;
		logic [127:0] name;
		logic [23:0] ctrl;
		word_t data;
		word_t exp_value;
		fd = $fopen(PATTERN_FILE, "r");
		if (fd != 0) begin
			while (!$feof(fd) && step_total < MAX_STEPS) begin
				n = $fgets(line, fd);
				if (n > 0 && line.getc(0) != "#") begin  // Skip column notes
					n = $sscanf(line, "%s %h %h %d %h", name, ctrl, data, flag, exp_value);
					if (n == 5) begin
						step_name[step_total] = name;
						step_ctrl[step_total] = ctrl;
						step_inport[step_total] = data;
						step_check[step_total] = (flag != 0);
						step_expect[step_total] = exp_value;
						step_total++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic drive_step(input int idx);
		apply_controls(step_ctrl[idx]);
		inport_data = step_inport[idx];
		test_name = step_name[idx];
		check_en = step_check[idx];
		expect_bus = step_expect[idx];
	endtask

	initial begin
		rst_n = 1'b0;
		apply_controls('0);
		inport_data = '0;
		check_en = 1'b0;
		test_name = '0;
		expect_bus = '0;
		read_patterns();
		if (step_total == 0) begin
			$display("Error: no test steps could be read from %s", PATTERN_FILE);
			$display("*** TEST FAILED ***");
			$finish;
		end else begin
			repeat (RESET_CYCLES) @(posedge clk);
			#2;
			rst_n = 1'b1;
			for (int i = 0; i < step_total; i++) begin
				drive_step(i);  // One micro-step per clock
				@(posedge clk);
				#2;
			end
			check_en = 1'b0;
			apply_controls('0);
			$display("Steps: %0d, checks: %0d, mismatches: %0d",
				step_total, check_count, mismatch_count);
			if (mismatch_count == 0 && check_count > 0)
				$display("*** TEST PASSED ***");
			else
				$display("*** TEST FAILED ***");
			$finish;
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= RESET_CYCLES + step_total + TIMEOUT_MARGIN) begin
			$display("Error: timeout after %0d cycles, the steps did not complete", cycle_count);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

endmodule

//--- sim/load_patterns.txt
# Columns: test name, control word (hex), inport data (hex), check flag, expected bus (hex)
# Control bits 19..0 are strobes and selects as ordered in cpu_system_tb, bits 23..20 alu_op
reset_pc 000080 00000000 1 00000000
reset_z 000200 00000000 1 00000000
reset_mdr 000100 00000000 1 00000000
fill_mar 040800 00000000 1 00000000
fill_mdr 004800 00800055 1 00800055
fill_mar 0C0800 00000001 1 00000001
fill_mdr 004800 01080055 1 01080055
fill_mar 0C0800 00000002 1 00000002
fill_mdr 004800 09880023 1 09880023
fill_mar 0C0800 00000003 1 00000003
fill_mdr 004800 0A000055 1 0A000055
fill_mar 0C0800 00000055 1 00000055
fill_mdr 004800 13572468 1 13572468
fill_mar 0C0800 00000087 1 00000087
fill_mdr 004800 5A5A0087 1 5A5A0087
readback_mar 0C0800 00000055 1 00000055
readback_load 004002 00000000 0 00000000
readback_mdr 000100 00000000 1 13572468
case1_t0 042081 00000000 1 00000000
case1_t1 004002 00000000 0 00000000
case1_t2 008100 00000000 1 00800055
case1_t3 010028 00000000 1 00000000
case1_t4 020400 00000000 1 00000055
case1_t5 040200 00000000 1 00000055
case1_t6 004002 00000000 0 00000000
case1_t7 001104 00000000 1 13572468
case1_ra 000044 00000000 1 13572468
case2_t0 042081 00000000 1 00000001
case2_t1 004002 00000000 0 00000000
case2_t2 008100 00000000 1 01080055
case2_r1 001808 00000032 1 00000032
case2_t3 010028 00000000 1 00000032
case2_t4 020400 00000000 1 00000055
case2_t5 040200 00000000 1 00000087
case2_t6 004002 00000000 0 00000000
case2_t7 001104 00000000 1 5A5A0087
case2_ra 000044 00000000 1 5A5A0087
case3_t0 042081 00000000 1 00000002
case3_t1 004002 00000000 0 00000000
case3_t2 008100 00000000 1 09880023
case3_r1 001808 0000000A 1 0000000A
case3_t3 010028 00000000 1 0000000A
case3_t4 020400 00000000 1 00000023
case3_t5 001204 00000000 1 0000002D
case3_ra 000044 00000000 1 0000002D
case4_t0 042081 00000000 1 00000003
case4_t1 004002 00000000 0 00000000
case4_t2 008100 00000000 1 0A000055
case4_t3 010028 00000000 1 00000000
case4_t4 020400 00000000 1 00000055
case4_t5 001204 00000000 1 00000055
case4_ra 000044 00000000 1 00000055
pc_after 000080 00000000 1 00000004
alu_y 010800 00000064 1 00000064
alu_ir 008800 0007FFFF 1 0007FFFF
alu_add_c 020400 00000000 1 FFFFFFFF
alu_add_z 000200 00000000 1 00000063
alu_sub 120800 0000001E 1 0000001E
alu_sub_z 000200 00000000 1 00000046
alu_and 220800 0000003C 1 0000003C
alu_and_z 000200 00000000 1 00000024
alu_or 320800 0000000B 1 0000000B
alu_or_z 000200 00000000 1 0000006F

//--- verilog.f
common/cpu_pkg.sv
datapath/register_file.sv
datapath/alu.sv
datapath/datapath.sv
src/select_encode.sv
src/main_memory.sv
src/cpu_system.sv
sim/bus_checker.sv
sim/cpu_system_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module cpu_system_tb -f verilog.f -o cpu_system_sim &&
./obj_dir/cpu_system_sim | tee /dev/stderr | grep -qF '*** TEST PASSED ***' &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
